/* Makefile */
# Verilator simulation of the board subsystem

VERILATOR ?= verilator
TOP       ?= tb_board_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
hdl/soc_cfg_pkg.sv
hdl/soc_regmap_pkg.sv
hdl/reset_ctrl.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_engine.sv
hdl/gpio_ctrl.sv
hdl/board_top.sv
testbench/tb_board_top.sv

/* hdl/board_top.sv */
/*
 * Board level top.
 * Reset and lock merge, UART host link, command engine and GPIO.
 * Pins come out as separate in, out and direction signals for the
 * pad ring to combine.
 */

`timescale 1ns/1ps

module board_top
  import soc_cfg_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_pll_locked,
  input  logic              i_uart_rd,
  input  logic [GPIO_W-1:0] i_gpio,
  output logic              o_uart_td,
  output logic [GPIO_W-1:0] o_gpio,
  output logic [GPIO_W-1:0] o_gpio_dir
);

  logic       w_sys_rst_n;
  logic [7:0] w_rx_data;
  logic       w_rx_valid;
  logic [7:0] w_tx_data;
  logic       w_tx_start;
  logic       w_tx_busy;
  // Register bus
  logic [7:0] w_reg_addr;
  logic [7:0] w_reg_wdata;
  logic       w_reg_we;
  logic       w_reg_re;
  logic [7:0] w_reg_rdata;

  reset_ctrl rstctrl0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_pll_locked(i_pll_locked),
    .o_sys_rst_n (w_sys_rst_n)
  );

  uart_rx uartrx0 (
    .i_clk  (i_clk),
    .i_rst_n(w_sys_rst_n),
    .i_rxd  (i_uart_rd),
    .o_data (w_rx_data),
    .o_valid(w_rx_valid)
  );

  uart_tx uarttx0 (
    .i_clk  (i_clk),
    .i_rst_n(w_sys_rst_n),
    .i_data (w_tx_data),
    .i_start(w_tx_start),
    .o_txd  (o_uart_td),
    .o_busy (w_tx_busy)
  );

  cmd_engine cmd0 (
    .i_clk      (i_clk),
    .i_rst_n    (w_sys_rst_n),
    .i_rx_data  (w_rx_data),
    .i_rx_valid (w_rx_valid),
    .i_tx_busy  (w_tx_busy),
    .i_reg_rdata(w_reg_rdata),
    .o_tx_data  (w_tx_data),
    .o_tx_start (w_tx_start),
    .o_reg_addr (w_reg_addr),
    .o_reg_wdata(w_reg_wdata),
    .o_reg_we   (w_reg_we),
    .o_reg_re   (w_reg_re)
  );

  gpio_ctrl gpio0 (
    .i_clk      (i_clk),
    .i_rst_n    (w_sys_rst_n),
    .i_reg_addr (w_reg_addr),
    .i_reg_wdata(w_reg_wdata),
    .i_reg_we   (w_reg_we),
    .i_reg_re   (w_reg_re),
    .i_gpio     (i_gpio),
    .o_reg_rdata(w_reg_rdata),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir)
  );

endmodule

/* hdl/cmd_engine.sv */
/*
 * Host command parser and register bus master.
 * Takes write frames (opcode, address, data) and read frames
 * (opcode, address) from the UART receiver, issues one register
 * access per frame and sends back an ack or the read data byte.
 */

`timescale 1ns/1ps

module cmd_engine
  import soc_regmap_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic [7:0] i_rx_data,
  input  logic       i_rx_valid,
  input  logic       i_tx_busy,
  input  logic [7:0] i_reg_rdata,
  output logic [7:0] o_tx_data,
  output logic       o_tx_start,
  output logic [7:0] o_reg_addr,
  output logic [7:0] o_reg_wdata,
  output logic       o_reg_we,
  output logic       o_reg_re
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_ACCESS,
    ST_REPLY
  } cmd_state_t;

  cmd_state_t r_state;
  logic       r_is_write;
  logic       r_tx_start;
  logic       r_reg_we;
  logic       r_reg_re;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_state    <= ST_IDLE;
      r_is_write <= 1'b0;
      r_tx_start <= 1'b0;
      r_reg_we   <= 1'b0;
      r_reg_re   <= 1'b0;
    end else begin
      r_tx_start <= 1'b0;
      case (r_state)
        ST_IDLE: begin
          // Anything but a known opcode is silently dropped
          if (i_rx_valid && (i_rx_data == OP_WRITE || i_rx_data == OP_READ)) begin
            r_is_write <= (i_rx_data == OP_WRITE);
            r_state    <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (i_rx_valid) begin
            r_reg_re <= !r_is_write;
            r_state  <= r_is_write ? ST_DATA : ST_ACCESS;
          end
        end
        ST_DATA: begin
          if (i_rx_valid) begin
            r_reg_we <= 1'b1;
            r_state  <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          // Strobe has been on the bus for one cycle, read data lands now
          r_reg_we <= 1'b0;
          r_reg_re <= 1'b0;
          r_state  <= ST_REPLY;
        end
        default: begin
          // Hold the reply until the transmitter is idle
          if (!i_tx_busy) begin
            r_tx_start <= 1'b1;
            r_state    <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Frame fields and the reply byte
  always_ff @(posedge i_clk) begin
    if (r_state == ST_ADDR && i_rx_valid) begin
      o_reg_addr <= i_rx_data;
    end
    if (r_state == ST_DATA && i_rx_valid) begin
      o_reg_wdata <= i_rx_data;
    end
    if (r_state == ST_REPLY && !i_tx_busy) begin
      o_tx_data <= r_is_write ? REPLY_ACK : i_reg_rdata;
    end
  end

  assign o_tx_start = r_tx_start;
  assign o_reg_we   = r_reg_we;
  assign o_reg_re   = r_reg_re;

endmodule

/* hdl/gpio_ctrl.sv */
/*
 * GPIO register block.
 * Output and direction registers plus synchronized input pins,
 * accessed through the byte-wide register bus. Read data is
 * registered and valid the cycle after i_reg_re.
 */

`timescale 1ns/1ps

module gpio_ctrl
  import soc_cfg_pkg::*, soc_regmap_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [7:0]        i_reg_addr,
  input  logic [7:0]        i_reg_wdata,
  input  logic              i_reg_we,
  input  logic              i_reg_re,
  input  logic [GPIO_W-1:0] i_gpio,
  output logic [7:0]        o_reg_rdata,
  output logic [GPIO_W-1:0] o_gpio,
  output logic [GPIO_W-1:0] o_gpio_dir
);

  logic [GPIO_W-1:0] r_out;
  logic [GPIO_W-1:0] r_dir;
  logic [GPIO_W-1:0] r_in_meta;
  logic [GPIO_W-1:0] r_in_sync;
  logic [15:0]       w_out_ext;
  logic [15:0]       w_dir_ext;
  logic [15:0]       w_in_ext;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_out <= '0;
      r_dir <= '0;
    end else if (i_reg_we) begin
      // High registers only keep the bits above 7
      case (i_reg_addr)
        ADDR_OUT_LO: r_out[7:0] <= i_reg_wdata;
        ADDR_OUT_HI: r_out[GPIO_W-1:8] <= i_reg_wdata[GPIO_W-9:0];
        ADDR_DIR_LO: r_dir[7:0] <= i_reg_wdata;
        ADDR_DIR_HI: r_dir[GPIO_W-1:8] <= i_reg_wdata[GPIO_W-9:0];
        default: ;
      endcase
    end
  end

  // Pins are asynchronous to i_clk
  always_ff @(posedge i_clk) begin
    r_in_meta <= i_gpio;
    r_in_sync <= r_in_meta;
  end

  // Zero-extended views so unused high bits read as 0
  assign w_out_ext = 16'(r_out);
  assign w_dir_ext = 16'(r_dir);
  assign w_in_ext  = 16'(r_in_sync);

  always_ff @(posedge i_clk) begin
    if (i_reg_re) begin
      case (i_reg_addr)
        ADDR_OUT_LO: o_reg_rdata <= w_out_ext[7:0];
        ADDR_OUT_HI: o_reg_rdata <= w_out_ext[15:8];
        ADDR_DIR_LO: o_reg_rdata <= w_dir_ext[7:0];
        ADDR_DIR_HI: o_reg_rdata <= w_dir_ext[15:8];
        ADDR_IN_LO:  o_reg_rdata <= w_in_ext[7:0];
        ADDR_IN_HI:  o_reg_rdata <= w_in_ext[15:8];
        default:     o_reg_rdata <= 8'h00;
      endcase
    end
  end

  assign o_gpio     = r_out;
  assign o_gpio_dir = r_dir;

endmodule

/* hdl/reset_ctrl.sv */
/*
 * System reset generator.
 * Combines the external reset with the PLL lock flag and keeps the
 * system reset asserted for RST_HOLD_CYCLES clean cycles afterwards.
 */

`timescale 1ns/1ps

module reset_ctrl
  import soc_cfg_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_pll_locked,
  output logic o_sys_rst_n
);

  logic [RST_CNT_W-1:0] r_hold_cnt;
  logic                 r_sys_rst_n;

  // The lock flag is sampled on every edge, and the counter only
  // advances while lock stays high, so a glitch restarts the hold
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || !i_pll_locked) begin
      r_hold_cnt  <= '0;
      r_sys_rst_n <= 1'b0;
    end else if (r_hold_cnt == RST_CNT_W'(RST_HOLD_CYCLES)) begin
      r_sys_rst_n <= 1'b1;
    end else begin
      r_hold_cnt <= r_hold_cnt + 1'b1;
    end
  end

  assign o_sys_rst_n = r_sys_rst_n;

endmodule

/* hdl/soc_cfg_pkg.sv */
/*
 * System configuration constants for the board subsystem.
 * Holds the clock and UART baud setup, the reset stretch length
 * and the GPIO width. Import it wherever these values are needed.
 */

package soc_cfg_pkg;

  // System clock from the board oscillator (40 ns period)
  localparam int unsigned CLK_FREQ_HZ = 25_000_000;

  // Host link baud rate
  localparam int unsigned BAUD_RATE = 1_562_500;

  // Clock cycles per UART bit, 16 at the rates above
  localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

  // Width of the bit-period counters in the UART
  localparam int unsigned BAUD_CNT_W = $clog2(CLKS_PER_BIT);

  // Cycles the system reset is held after reset and lock are both clean
  localparam int unsigned RST_HOLD_CYCLES = 8;

  // Width of the reset stretch counter, it must reach RST_HOLD_CYCLES
  localparam int unsigned RST_CNT_W = $clog2(RST_HOLD_CYCLES + 1);

  // Number of GPIO pins on the board header
  // [11:4] LEDs, [3:0] DIP switch on the usual board wiring
  localparam int unsigned GPIO_W = 12;

endpackage

/* hdl/soc_regmap_pkg.sv */
/*
 * Host command protocol and GPIO register map.
 * Opcodes and the reply code are the bytes seen on the UART link,
 * register addresses are the second byte of every frame.
 */

package soc_regmap_pkg;

  // Frame opcodes
  localparam logic [7:0] OP_WRITE = 8'h57;
  localparam logic [7:0] OP_READ = 8'h52;

  // Returned after every write frame
  localparam logic [7:0] REPLY_ACK = 8'h4B;

  // Output pin register, high byte uses the low nibble only
  localparam logic [7:0] ADDR_OUT_LO = 8'h00;
  localparam logic [7:0] ADDR_OUT_HI = 8'h01;

  // Direction register, a 1 drives the pin
  localparam logic [7:0] ADDR_DIR_LO = 8'h02;
  localparam logic [7:0] ADDR_DIR_HI = 8'h03;

  // Input pin state, read-only
  localparam logic [7:0] ADDR_IN_LO = 8'h04;
  localparam logic [7:0] ADDR_IN_HI = 8'h05;

  // Every other address is unmapped and reads as zero

endpackage

/* hdl/uart_rx.sv */
/*
 * UART receiver, 8N1, fixed rate from soc_cfg_pkg.
 * Each byte appears on o_data together with a one-cycle o_valid
 * near the middle of its stop bit. Framing errors are dropped.
 */

`timescale 1ns/1ps

module uart_rx
  import soc_cfg_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_rxd,
  output logic [7:0] o_data,
  output logic       o_valid
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t             r_state;
  logic [1:0]            r_sync;
  logic [BAUD_CNT_W-1:0] r_clk_cnt;
  logic [2:0]            r_bit_idx;
  logic [7:0]            r_shift;
  logic                  r_valid;
  logic                  w_rxd;
  logic                  w_bit_end;

  assign w_rxd     = r_sync[1];
  assign w_bit_end = (r_clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      // Line idles high
      r_sync    <= 2'b11;
      r_state   <= RX_IDLE;
      r_clk_cnt <= '0;
      r_bit_idx <= '0;
      r_valid   <= 1'b0;
    end else begin
      r_sync  <= {r_sync[0], i_rxd};
      r_valid <= 1'b0;
      case (r_state)
        RX_IDLE: begin
          r_clk_cnt <= '0;
          if (!w_rxd) begin
            r_state <= RX_START;
          end
        end
        RX_START: begin
          // Recheck the start bit at its middle to reject glitches
          if (r_clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            r_clk_cnt <= '0;
            r_bit_idx <= '0;
            r_state   <= w_rxd ? RX_IDLE : RX_DATA;
          end else begin
            r_clk_cnt <= r_clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          r_clk_cnt <= w_bit_end ? '0 : r_clk_cnt + 1'b1;
          if (w_bit_end) begin
            r_bit_idx <= r_bit_idx + 1'b1;
            if (r_bit_idx == 3'd7) begin
              r_state <= RX_STOP;
            end
          end
        end
        default: begin
          r_clk_cnt <= w_bit_end ? '0 : r_clk_cnt + 1'b1;
          if (w_bit_end) begin
            r_valid <= w_rxd;
            r_state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge i_clk) begin
    if (r_state == RX_DATA && w_bit_end) begin
      r_shift <= {w_rxd, r_shift[7:1]};
    end
  end

  assign o_data  = r_shift;
  assign o_valid = r_valid;

endmodule

/* hdl/uart_tx.sv */
/*
 * UART transmitter, 8N1, fixed rate from soc_cfg_pkg.
 * Pulse i_start for one cycle while o_busy is low to send i_data.
 * o_busy stays high until the stop bit has finished.
 */

`timescale 1ns/1ps

module uart_tx
  import soc_cfg_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic [7:0] i_data,
  input  logic       i_start,
  output logic       o_txd,
  output logic       o_busy
);

  logic [8:0]            r_shift;
  logic [BAUD_CNT_W-1:0] r_clk_cnt;
  logic [3:0]            r_bit_cnt;
  logic                  r_txd;
  logic                  r_busy;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_shift   <= '1;
      r_clk_cnt <= '0;
      r_bit_cnt <= '0;
      r_txd     <= 1'b1;
      r_busy    <= 1'b0;
    end else if (!r_busy) begin
      if (i_start) begin
        // Stop bit sits above the data, the start bit goes out now
        r_shift   <= {1'b1, i_data};
        r_clk_cnt <= '0;
        r_bit_cnt <= '0;
        r_txd     <= 1'b0;
        r_busy    <= 1'b1;
      end
    end else if (r_clk_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
      r_clk_cnt <= '0;
      if (r_bit_cnt == 4'd9) begin
        // End of stop bit, line is already high
        r_busy <= 1'b0;
      end else begin
        r_txd     <= r_shift[0];
        r_shift   <= {1'b1, r_shift[8:1]};
        r_bit_cnt <= r_bit_cnt + 1'b1;
      end
    end else begin
      r_clk_cnt <= r_clk_cnt + 1'b1;
    end
  end

  assign o_txd  = r_txd;
  assign o_busy = r_busy;

endmodule

/* testbench/tb_board_top.sv */
/*
 * Testbench for the board top level.
 * A UART host model sends write and read frames, a monitor collects
 * the reply bytes, and assertions compare pins and replies with a
 * reference model of the GPIO register map.
 */

`timescale 1ns/1ps

module tb_board_top
  import soc_cfg_pkg::*, soc_regmap_pkg::*;
();

  localparam int unsigned CLK_PERIOD    = 40;
  localparam int unsigned BYTE_CYCLES   = 10 * CLKS_PER_BIT;
  // Three frame bytes plus the reply byte
  localparam int unsigned FRAME_CYCLES  = 4 * BYTE_CYCLES;
  localparam int unsigned REPLY_TIMEOUT = 3 * BYTE_CYCLES;
  localparam int unsigned ROUNDS        = 4;
  // Ten frames per round plus the edge case and lock loss frames
  localparam int unsigned NUM_FRAMES    = 53;
  localparam int unsigned WATCHDOG_NS   = (NUM_FRAMES * FRAME_CYCLES + 2000) * CLK_PERIOD;
  localparam logic [31:0] SEED          = 32'ha570_1f46;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              pll_locked;
  logic              uart_rd;
  logic [GPIO_W-1:0] gpio_in;
  logic              uart_td;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;

  // Reference model of the output and direction registers
  logic [GPIO_W-1:0] exp_out;
  logic [GPIO_W-1:0] exp_dir;
  logic [7:0]        reply_q[$];
  bit                mon_en = 1'b0;
  int                value_errors = 0;
  int                other_errors = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  board_top u_dut (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_pll_locked(pll_locked),
    .i_uart_rd   (uart_rd),
    .i_gpio      (gpio_in),
    .o_uart_td   (uart_td),
    .o_gpio      (gpio_out),
    .o_gpio_dir  (gpio_dir)
  );

  // Lock loss resets the system, and the GPIO registers clear one edge later
  assert property (@(posedge clk) $fell(pll_locked) |-> ##2 (gpio_out == '0))
    else begin
      $display("[ERROR] o_gpio after lock loss: expected 0x000, actual 0x%03h", gpio_out);
      value_errors++;
    end

  assert property (@(posedge clk) $fell(pll_locked) |-> ##2 (gpio_dir == '0))
    else begin
      $display("[ERROR] o_gpio_dir after lock loss: expected 0x000, actual 0x%03h", gpio_dir);
      value_errors++;
    end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_pins();
    assert (gpio_out === exp_out) else begin
      $display("[ERROR] o_gpio: expected 0x%03h, actual 0x%03h", exp_out, gpio_out);
      value_errors++;
    end
    assert (gpio_dir === exp_dir) else begin
      $display("[ERROR] o_gpio_dir: expected 0x%03h, actual 0x%03h", exp_dir, gpio_dir);
      value_errors++;
    end
  endtask

  // Sends one byte on the host link starting at a falling edge
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rd = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  task automatic wait_reply(output logic [7:0] b, output bit got);
    int cnt;
    cnt = 0;
    b   = 8'h00;
    got = 1'b0;
    while (reply_q.size() == 0 && cnt < REPLY_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (reply_q.size() != 0) begin
      b   = reply_q.pop_front();
      got = 1'b1;
    end else begin
      $display("No reply byte on o_uart_td within %0d cycles", REPLY_TIMEOUT);
      other_errors++;
    end
  endtask

  function automatic logic [7:0] expected_read(input logic [7:0] addr);
    case (addr)
      ADDR_OUT_LO: return exp_out[7:0];
      ADDR_OUT_HI: return {4'h0, exp_out[11:8]};
      ADDR_DIR_LO: return exp_dir[7:0];
      ADDR_DIR_HI: return {4'h0, exp_dir[11:8]};
      ADDR_IN_LO:  return gpio_in[7:0];
      ADDR_IN_HI:  return {4'h0, gpio_in[11:8]};
      default:     return 8'h00;
    endcase
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [7:0] reply;
    bit         got;
    send_byte(OP_WRITE);
    send_byte(addr);
    send_byte(data);
    wait_reply(reply, got);
    if (got) begin
      check_byte($sformatf("o_uart_td ack for write 0x%02h", addr), REPLY_ACK, reply);
    end
    // High halves take the low nibble and other addresses change nothing
    case (addr)
      ADDR_OUT_LO: exp_out[7:0] = data;
      ADDR_OUT_HI: exp_out[11:8] = data[3:0];
      ADDR_DIR_LO: exp_dir[7:0] = data;
      ADDR_DIR_HI: exp_dir[11:8] = data[3:0];
      default: ;
    endcase
    check_pins();
  endtask

  task automatic read_and_check(input logic [7:0] addr);
    logic [7:0] data;
    bit         got;
    send_byte(OP_READ);
    send_byte(addr);
    wait_reply(data, got);
    if (got) begin
      check_byte($sformatf("o_uart_td read 0x%02h", addr), expected_read(addr), data);
    end
  endtask

  // Reply receiver that samples each bit near its middle
  initial begin : uart_monitor
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (mon_en && uart_td === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (uart_td !== 1'b0) begin
          $display("Start bit on o_uart_td ended before its middle");
          other_errors++;
        end else begin
          for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_td;
          end
          repeat (CLKS_PER_BIT) @(negedge clk);
          if (uart_td !== 1'b1) begin
            $display("Reply byte on o_uart_td has no stop bit");
            other_errors++;
          end else begin
            reply_q.push_back(b);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    logic [7:0] op;
    rst_n      = 1'b0;
    pll_locked = 1'b1;
    uart_rd    = 1'b1;
    gpio_in    = '0;
    exp_out    = '0;
    exp_dir    = '0;
    void'($urandom(SEED));

    repeat (4) @(negedge clk);
    check_pins();
    assert (uart_td === 1'b1) else begin
      $display("[ERROR] o_uart_td in reset: expected 0x1, actual 0x%01h", uart_td);
      value_errors++;
    end
    rst_n = 1'b1;
    repeat (RST_HOLD_CYCLES + 4) @(negedge clk);
    check_pins();
    assert (uart_td === 1'b1) else begin
      $display("[ERROR] o_uart_td after reset: expected 0x1, actual 0x%01h", uart_td);
      value_errors++;
    end
    mon_en = 1'b1;

    // Random writes followed by a read of every register
    for (int r = 0; r < ROUNDS; r++) begin
      write_reg(ADDR_OUT_LO, 8'($urandom));
      write_reg(ADDR_OUT_HI, 8'($urandom));
      write_reg(ADDR_DIR_LO, 8'($urandom));
      write_reg(ADDR_DIR_HI, 8'($urandom));
      gpio_in = GPIO_W'($urandom);
      read_and_check(ADDR_OUT_LO);
      read_and_check(ADDR_OUT_HI);
      read_and_check(ADDR_DIR_LO);
      read_and_check(ADDR_DIR_HI);
      read_and_check(ADDR_IN_LO);
      read_and_check(ADDR_IN_HI);
    end

    // Unknown opcode must be dropped without a reply
    do begin
      op = 8'($urandom);
    end while (op == OP_WRITE || op == OP_READ);
    send_byte(op);
    repeat (2 * FRAME_CYCLES) @(negedge clk);
    if (reply_q.size() != 0) begin
      $display("Reply sent for unknown opcode 0x%02h", op);
      other_errors++;
      reply_q.delete();
    end
    write_reg(ADDR_OUT_LO, 8'($urandom));
    read_and_check(ADDR_OUT_LO);

    read_and_check(8'(6 + $urandom_range(0, 249)));
    write_reg(ADDR_IN_LO, 8'($urandom));
    read_and_check(ADDR_IN_LO);

    // Lock loss with nonzero registers and the recovery after it
    write_reg(ADDR_OUT_LO, 8'($urandom) | 8'h01);
    write_reg(ADDR_DIR_LO, 8'($urandom) | 8'h01);
    pll_locked = 1'b0;
    repeat (4) @(negedge clk);
    exp_out = '0;
    exp_dir = '0;
    check_pins();
    pll_locked = 1'b1;
    repeat (RST_HOLD_CYCLES + 4) @(negedge clk);
    write_reg(ADDR_OUT_HI, 8'($urandom));
    read_and_check(ADDR_OUT_HI);

    repeat (BYTE_CYCLES) @(negedge clk);
    if (reply_q.size() != 0) begin
      $display("Unexpected extra reply bytes: %0d", reply_q.size());
      other_errors++;
    end
    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
